// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Operand and result width
`define CPU_OPW 32

// Register address width and register count
`define CPU_RAW 5
`define CPU_NREGS 32

// Cycles a MUL keeps the execute stage busy
`define CPU_MUL_CYCLES 3

`endif

// File: common/isa_pkg.sv
`include "cpu_defs.svh"

package isa_pkg;

   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_ADDI = 4'h3,
      OP_MUL  = 4'h4
   } opcode_e;

   // Register form: rd = ra op rb
   typedef struct packed {
      opcode_e             op;
      logic [`CPU_RAW-1:0] rd;
      logic [`CPU_RAW-1:0] ra;
      logic [`CPU_RAW-1:0] rb;
      logic [12:0]         unused;
   } insn_reg_t;

   // Immediate form: rd = ra + sext(imm)
   typedef struct packed {
      opcode_e             op;
      logic [`CPU_RAW-1:0] rd;
      logic [`CPU_RAW-1:0] ra;
      logic signed [17:0]  imm;
   } insn_imm_t;

   // Both views share the opcode, rd and ra positions
   typedef union packed {
      insn_reg_t r;
      insn_imm_t i;
   } insn_u;

endpackage

// File: common/pipe_pkg.sv
`include "cpu_defs.svh"

package pipe_pkg;

   // Controller sequencing
   typedef enum logic [1:0] {
      RESET_WAIT = 2'd0,
      RUN        = 2'd1,
      MUL_BUSY   = 2'd2
   } ctrl_state_e;

   // Where an operand came from when it entered execute
   typedef enum logic [1:0] {
      RAM      = 2'd0,
      EXEC_FWD = 2'd1,
      CTRL_FWD = 2'd2,
      WB_FWD   = 2'd3
   } opnd_src_e;

endpackage

// File: rf/rf_dpram.sv
`include "cpu_defs.svh"

module rf_dpram #(
   parameter int ADDR_W = `CPU_RAW,
   parameter int DATA_W = `CPU_OPW
) (
   input  logic              clk,
   input  logic              re_i,
   input  logic [ADDR_W-1:0] raddr_i,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic [DATA_W-1:0] din_i,
   output logic [DATA_W-1:0] dout_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   // All registers start out as zero
   initial begin
      for (int k = 0; k < 2**ADDR_W; k++) begin
         mem[k] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Read returns the old word on a same-cycle write
   always_ff @(posedge clk) begin
      if (re_i) begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

// File: rf/rf_bypass.sv
`include "cpu_defs.svh"

module rf_bypass (
   input  logic                clk,
   input  logic                rst,
   input  logic                padv_decode_i,
   input  logic                decode_valid_i,
   input  logic                fetch_rf_adr_valid_i,
   input  logic [`CPU_RAW-1:0] fetch_rfa_adr_i,
   input  logic [`CPU_RAW-1:0] fetch_rfb_adr_i,
   input  logic [`CPU_RAW-1:0] decode_rfa_adr_i,
   input  logic [`CPU_RAW-1:0] decode_rfb_adr_i,
   input  logic [`CPU_RAW-1:0] execute_rfd_adr_i,
   input  logic [`CPU_RAW-1:0] ctrl_rfd_adr_i,
   input  logic [`CPU_RAW-1:0] wb_rfd_adr_i,
   input  logic                execute_rf_wb_i,
   input  logic                ctrl_rf_wb_i,
   input  logic                wb_rf_wb_i,
   input  logic [`CPU_OPW-1:0] result_i,
   input  logic [`CPU_OPW-1:0] ctrl_alu_result_i,
   output logic [`CPU_OPW-1:0] decode_rfa_o,
   output logic [`CPU_OPW-1:0] decode_rfb_o,
   output logic [`CPU_OPW-1:0] execute_rfa_o,
   output logic [`CPU_OPW-1:0] execute_rfb_o
);

   // Index 0 is port a, index 1 is port b
   logic [`CPU_RAW-1:0] fetch_adr [2];
   logic [`CPU_RAW-1:0] decode_adr [2];
   logic [`CPU_OPW-1:0] ram_dout [2];
   logic [`CPU_OPW-1:0] decode_opnd [2];
   logic [`CPU_OPW-1:0] execute_opnd [2];

   assign fetch_adr[0] = fetch_rfa_adr_i;
   assign fetch_adr[1] = fetch_rfb_adr_i;
   assign decode_adr[0] = decode_rfa_adr_i;
   assign decode_adr[1] = decode_rfb_adr_i;

   assign decode_rfa_o = decode_opnd[0];
   assign decode_rfb_o = decode_opnd[1];
   assign execute_rfa_o = execute_opnd[0];
   assign execute_rfb_o = execute_opnd[1];

   for (genvar p = 0; p < 2; p++) begin : g_port
      logic                ctrl_match;
      logic                wb_match;
      logic                exec_match;
      logic                held_valid;
      logic [`CPU_OPW-1:0] held_result;
      logic [`CPU_OPW-1:0] execute_r;
      pipe_pkg::opnd_src_e execute_src;

      rf_dpram #(
         .ADDR_W (`CPU_RAW),
         .DATA_W (`CPU_OPW)
      ) u_ram (
         .clk     (clk),
         .re_i    (fetch_rf_adr_valid_i),
         .raddr_i (fetch_adr[p]),
         .we_i    (wb_rf_wb_i),
         .waddr_i (wb_rfd_adr_i),
         .din_i   (result_i),
         .dout_o  (ram_dout[p])
      );

      assign ctrl_match = ctrl_rf_wb_i & (ctrl_rfd_adr_i == decode_adr[p]);
      assign wb_match = wb_rf_wb_i & (wb_rfd_adr_i == decode_adr[p]);
      assign exec_match = execute_rf_wb_i & (execute_rfd_adr_i == decode_adr[p]);

      // The RAM output is stale for any write after the read was taken,
      // so keep the latest write to the decode address until the next fetch
      always_ff @(posedge clk) begin
         if (rst) begin
            held_valid <= 1'b0;
         end else if (fetch_rf_adr_valid_i) begin
            held_valid <= wb_rf_wb_i & (wb_rfd_adr_i == fetch_adr[p]);
         end else if (wb_match) begin
            held_valid <= 1'b1;
         end
      end

      always_ff @(posedge clk) begin
         if (fetch_rf_adr_valid_i | wb_match) begin
            held_result <= result_i;
         end
      end

      // Youngest producer first
      assign decode_opnd[p] = ctrl_match  ? ctrl_alu_result_i :
                              wb_match    ? result_i :
                              held_valid  ? held_result :
                              ram_dout[p];

      // A producer still in execute when decode advances shows up in ctrl
      // on the next cycle and stays there until execute advances again
      always_ff @(posedge clk) begin
         if (rst) begin
            execute_src <= pipe_pkg::RAM;
         end else if (padv_decode_i) begin
            if (decode_valid_i & exec_match) begin
               execute_src <= pipe_pkg::EXEC_FWD;
            end else if (ctrl_match) begin
               execute_src <= pipe_pkg::CTRL_FWD;
            end else if (wb_match | held_valid) begin
               execute_src <= pipe_pkg::WB_FWD;
            end else begin
               execute_src <= pipe_pkg::RAM;
            end
         end
      end

      always_ff @(posedge clk) begin
         if (padv_decode_i) begin
            execute_r <= decode_opnd[p];
         end
      end

      assign execute_opnd[p] = (execute_src == pipe_pkg::EXEC_FWD) ?
                               ctrl_alu_result_i : execute_r;
   end

endmodule

// File: hdl/mul_timer.sv
`include "cpu_defs.svh"

module mul_timer (
   input  logic clk,
   input  logic rst,
   input  logic start_i,
   input  logic hold_i,
   output logic done_o
);

   logic [$clog2(`CPU_MUL_CYCLES+1)-1:0] count;

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (start_i) begin
         count <= ($bits(count))'(`CPU_MUL_CYCLES - 1);
      end else if (!hold_i && count != '0) begin
         count <= count - 1'b1;
      end
   end

   assign done_o = (count == '0);

endmodule

// File: hdl/pipe_ctrl.sv
`include "cpu_defs.svh"

module pipe_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic stall_i,
   input  logic exec_is_mul_i,
   input  logic mul_done_i,
   output logic mul_start_o,
   output logic padv_fetch_o,
   output logic padv_decode_o,
   output logic padv_execute_o,
   output logic padv_ctrl_o
);

   pipe_pkg::ctrl_state_e state;
   logic front_adv;

   assign mul_start_o = (state == pipe_pkg::RUN) & exec_is_mul_i & !stall_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= pipe_pkg::RESET_WAIT;
      end else begin
         case (state)
            pipe_pkg::RESET_WAIT: state <= pipe_pkg::RUN;
            pipe_pkg::RUN: begin
               if (mul_start_o) begin
                  state <= pipe_pkg::MUL_BUSY;
               end
            end
            pipe_pkg::MUL_BUSY: begin
               if (mul_done_i && !stall_i) begin
                  state <= pipe_pkg::RUN;
               end
            end
            default: state <= pipe_pkg::RESET_WAIT;
         endcase
      end
   end

   // Front of the pipe moves in RUN unless a MUL just reached execute,
   // and in MUL_BUSY only once the multiply has finished
   always_comb begin
      case (state)
         pipe_pkg::RUN:      front_adv = !stall_i & !exec_is_mul_i;
         pipe_pkg::MUL_BUSY: front_adv = !stall_i & mul_done_i;
         default:            front_adv = 1'b0;
      endcase
   end

   assign padv_fetch_o = front_adv;
   assign padv_decode_o = front_adv;
   assign padv_execute_o = front_adv;
   // Ctrl and writeback drain while the MUL holds execute
   assign padv_ctrl_o = (state != pipe_pkg::RESET_WAIT) & !stall_i;

endmodule

// File: hdl/exec_unit.sv
`include "cpu_defs.svh"

module exec_unit (
   input  logic                clk,
   input  logic                rst,
   input  logic [31:0]         instr_i,
   input  logic                padv_fetch_i,
   input  logic                padv_decode_i,
   input  logic                padv_execute_i,
   input  logic                padv_ctrl_i,
   input  logic [`CPU_OPW-1:0] decode_rfa_i,
   input  logic [`CPU_OPW-1:0] decode_rfb_i,
   input  logic [`CPU_OPW-1:0] execute_rfa_i,
   input  logic [`CPU_OPW-1:0] execute_rfb_i,
   output logic                exec_is_mul_o,
   output logic                decode_valid_o,
   output logic [`CPU_RAW-1:0] decode_rfa_adr_o,
   output logic [`CPU_RAW-1:0] decode_rfb_adr_o,
   output logic [`CPU_RAW-1:0] fetch_rfa_adr_o,
   output logic [`CPU_RAW-1:0] fetch_rfb_adr_o,
   output logic [`CPU_RAW-1:0] execute_rfd_adr_o,
   output logic                execute_rf_wb_o,
   output logic [`CPU_RAW-1:0] ctrl_rfd_adr_o,
   output logic                ctrl_rf_wb_o,
   output logic [`CPU_OPW-1:0] ctrl_alu_result_o,
   output logic [`CPU_RAW-1:0] wb_rfd_adr_o,
   output logic                wb_rf_wb_o,
   output logic [`CPU_OPW-1:0] result_o
);

   isa_pkg::insn_u fetch_insn;
   isa_pkg::insn_u decode_insn;
   isa_pkg::insn_u exec_insn;
   logic decode_vld;
   logic exec_vld;
   logic [`CPU_OPW-1:0] opnd_b;
   logic [`CPU_OPW-1:0] alu_result;

   assign fetch_insn = instr_i;
   assign fetch_rfa_adr_o = fetch_insn.r.ra;
   assign fetch_rfb_adr_o = fetch_insn.r.rb;
   assign decode_rfa_adr_o = decode_insn.r.ra;
   assign decode_rfb_adr_o = decode_insn.r.rb;

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_vld <= 1'b0;
         exec_vld <= 1'b0;
      end else begin
         if (padv_fetch_i) decode_vld <= 1'b1;
         if (padv_decode_i) exec_vld <= decode_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_fetch_i) decode_insn <= fetch_insn;
      if (padv_decode_i) exec_insn <= decode_insn;
   end

   // Decode advances with a live instruction in it
   assign decode_valid_o = padv_decode_i & decode_vld;

   assign exec_is_mul_o = exec_vld & (exec_insn.r.op == isa_pkg::OP_MUL);
   assign execute_rfd_adr_o = exec_insn.r.rd;
   assign execute_rf_wb_o = exec_vld & (exec_insn.r.op != isa_pkg::OP_NOP);

   assign opnd_b = (exec_insn.i.op == isa_pkg::OP_ADDI) ?
                   {{(`CPU_OPW-18){exec_insn.i.imm[17]}}, exec_insn.i.imm} :
                   execute_rfb_i;

   always_comb begin
      case (exec_insn.r.op)
         isa_pkg::OP_SUB: alu_result = execute_rfa_i - opnd_b;
         isa_pkg::OP_MUL: alu_result = execute_rfa_i * opnd_b;
         default:         alu_result = execute_rfa_i + opnd_b;
      endcase
   end

   // MUL result lands in ctrl on the advance that ends the multiply
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_rf_wb_o <= 1'b0;
         wb_rf_wb_o <= 1'b0;
      end else begin
         if (padv_ctrl_i) ctrl_rf_wb_o <= padv_execute_i & execute_rf_wb_o;
         // One writeback pulse per retiring instruction
         wb_rf_wb_o <= padv_ctrl_i & ctrl_rf_wb_o;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_execute_i) begin
         ctrl_rfd_adr_o <= execute_rfd_adr_o;
         ctrl_alu_result_o <= alu_result;
      end
      if (padv_ctrl_i) begin
         wb_rfd_adr_o <= ctrl_rfd_adr_o;
         result_o <= ctrl_alu_result_o;
      end
   end

endmodule

// File: hdl/core_top.sv
`include "cpu_defs.svh"

module core_top (
   input  logic                clk,
   input  logic                rst,
   input  logic [31:0]         instr_i,
   input  logic                stall_i,
   output logic                fetch_adv_o,
   output logic                wb_we_o,
   output logic [`CPU_RAW-1:0] wb_adr_o,
   output logic [`CPU_OPW-1:0] wb_dat_o
);

   isa_pkg::insn_u fetch_insn;
   logic padv_fetch, padv_decode, padv_execute, padv_ctrl;
   logic exec_is_mul, mul_start, mul_done, decode_valid;
   logic [`CPU_RAW-1:0] fetch_rfa_adr, fetch_rfb_adr;
   logic [`CPU_RAW-1:0] decode_rfa_adr, decode_rfb_adr;
   logic [`CPU_RAW-1:0] execute_rfd_adr, ctrl_rfd_adr;
   logic execute_rf_wb, ctrl_rf_wb;
   logic [`CPU_OPW-1:0] ctrl_alu_result;
   logic [`CPU_OPW-1:0] decode_rfa, decode_rfb, execute_rfa, execute_rfb;

   assign fetch_insn = instr_i;
   assign fetch_adv_o = padv_fetch;

   pipe_ctrl u_ctrl (
      .clk (clk), .rst (rst), .stall_i (stall_i),
      .exec_is_mul_i (exec_is_mul), .mul_done_i (mul_done),
      .mul_start_o (mul_start), .padv_fetch_o (padv_fetch),
      .padv_decode_o (padv_decode), .padv_execute_o (padv_execute),
      .padv_ctrl_o (padv_ctrl)
   );

   mul_timer u_timer (
      .clk (clk), .rst (rst), .start_i (mul_start), .hold_i (stall_i),
      .done_o (mul_done)
   );

   exec_unit u_exec (
      .clk (clk), .rst (rst), .instr_i (fetch_insn),
      .padv_fetch_i (padv_fetch), .padv_decode_i (padv_decode),
      .padv_execute_i (padv_execute), .padv_ctrl_i (padv_ctrl),
      .decode_rfa_i (decode_rfa), .decode_rfb_i (decode_rfb),
      .execute_rfa_i (execute_rfa), .execute_rfb_i (execute_rfb),
      .exec_is_mul_o (exec_is_mul), .decode_valid_o (decode_valid),
      .decode_rfa_adr_o (decode_rfa_adr), .decode_rfb_adr_o (decode_rfb_adr),
      .fetch_rfa_adr_o (fetch_rfa_adr), .fetch_rfb_adr_o (fetch_rfb_adr),
      .execute_rfd_adr_o (execute_rfd_adr), .execute_rf_wb_o (execute_rf_wb),
      .ctrl_rfd_adr_o (ctrl_rfd_adr), .ctrl_rf_wb_o (ctrl_rf_wb),
      .ctrl_alu_result_o (ctrl_alu_result), .wb_rfd_adr_o (wb_adr_o),
      .wb_rf_wb_o (wb_we_o), .result_o (wb_dat_o)
   );

   rf_bypass u_rf (
      .clk (clk), .rst (rst), .padv_decode_i (padv_decode),
      .decode_valid_i (decode_valid), .fetch_rf_adr_valid_i (padv_fetch),
      .fetch_rfa_adr_i (fetch_rfa_adr), .fetch_rfb_adr_i (fetch_rfb_adr),
      .decode_rfa_adr_i (decode_rfa_adr), .decode_rfb_adr_i (decode_rfb_adr),
      .execute_rfd_adr_i (execute_rfd_adr), .ctrl_rfd_adr_i (ctrl_rfd_adr),
      .wb_rfd_adr_i (wb_adr_o), .execute_rf_wb_i (execute_rf_wb),
      .ctrl_rf_wb_i (ctrl_rf_wb), .wb_rf_wb_i (wb_we_o),
      .result_i (wb_dat_o), .ctrl_alu_result_i (ctrl_alu_result),
      .decode_rfa_o (decode_rfa), .decode_rfb_o (decode_rfb),
      .execute_rfa_o (execute_rfa), .execute_rfb_o (execute_rfb)
   );

endmodule

// File: dv/tb_core.sv
`include "cpu_defs.svh"

module tb_core;
   timeunit 1ns;
   timeprecision 1ps;

   logic                clk;
   logic                rst;
   logic [31:0]         instr_i;
   logic                stall_i;
   logic                fetch_adv_o;
   logic                wb_we_o;
   logic [`CPU_RAW-1:0] wb_adr_o;
   logic [`CPU_OPW-1:0] wb_dat_o;

   // Instruction stream and expected writebacks, in retirement order
   logic [31:0] prog [$];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   int errors = 0;
   int seed = 32'h3bf0_8029;
   bit timed_out = 1'b0;

   core_top DUT (
      .clk         (clk),
      .rst         (rst),
      .instr_i     (instr_i),
      .stall_i     (stall_i),
      .fetch_adv_o (fetch_adv_o),
      .wb_we_o     (wb_we_o),
      .wb_adr_o    (wb_adr_o),
      .wb_dat_o    (wb_dat_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic load_trace();
      int fd;
      int n;
      string line;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("dv/core_trace.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open the trace file dv/core_trace.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            // Lines other than I and W are comments
            if (line.getc(0) == "I") begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
               if (n == 1) prog.push_back(a);
            end else if (line.getc(0) == "W") begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
               if (n == 2) begin
                  exp_adr.push_back(a);
                  exp_dat.push_back(b);
               end
            end
         end
         $fclose(fd);
      end
      if (prog.size() == 0 || exp_adr.size() == 0) begin
         errors++;
         $display("The trace holds no instructions or no expected writebacks");
      end
   endtask

   // NOP words once the stream has run out
   function automatic logic [31:0] next_word(input int idx);
      if (idx < prog.size()) begin
         return prog[idx];
      end else begin
         return 32'h0;
      end
   endfunction

   task automatic run_pass(input bit use_stall);
      int issued;
      int seen;
      int cycles;
      int limit;
      issued = 0;
      seen = 0;
      cycles = 0;
      limit = 10 * prog.size() + 50;
      rst <= 1'b1;
      stall_i <= 1'b0;
      instr_i <= 32'h0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      instr_i <= next_word(0);
      @(posedge clk);
      // Controller still in its reset wait state here
      check_value("fetch_adv_o after reset", 32'(fetch_adv_o), 32'd0);
      check_value("wb_we_o after reset", 32'(wb_we_o), 32'd0);
      while (seen < exp_adr.size() && cycles < limit) begin
         @(posedge clk);
         cycles++;
         if (wb_we_o) begin
            if (issued == 0) begin
               errors++;
               $display("Writeback at %0d ns before any instruction was fetched", $time);
            end
            check_value("writeback address", 32'(wb_adr_o), exp_adr[seen]);
            check_value("writeback data", wb_dat_o, exp_dat[seen]);
            seen++;
         end
         if (fetch_adv_o) begin
            issued++;
            instr_i <= next_word(issued);
         end
         stall_i <= use_stall && (($random(seed) & 3) == 0);
      end
      if (seen < exp_adr.size()) begin
         errors++;
         timed_out = 1'b1;
         $display("Timeout after %0d cycles: %0d of %0d writebacks still missing",
                  cycles, exp_adr.size() - seen, exp_adr.size());
      end else begin
         // Pipe drains with NOPs, so nothing else may retire
         repeat (20) begin
            @(posedge clk);
            if (wb_we_o) begin
               errors++;
               $display("Extra writeback to r%0d at %0d ns after the expected list ended",
                        wb_adr_o, $time);
            end
            if (fetch_adv_o) begin
               issued++;
               instr_i <= next_word(issued);
            end
            stall_i <= 1'b0;
         end
      end
   endtask

   initial begin
      rst = 1'b1;
      stall_i = 1'b0;
      instr_i = 32'h0;
      load_trace();
      run_pass(1'b0);
      // Same stream again with random back-pressure
      if (!timed_out) begin
         run_pass(1'b1);
      end
      $display("tb_core finished with %0d error(s)", errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: dv/core_trace.txt
# I <instruction word, hex>
# W <destination register, hex> <write data, hex>, in retirement order
I 30800005
W 01 00000005
I 3103fffd
W 02 fffffffd
I 31801234
W 03 00001234
I 12086000
W 04 00001231
I 22844000
W 05 00000008
I 34000064
W 08 00000064
I 34800200
W 09 00000200
I 15212000
W 0a 00000264
I 25a14000
W 0b fffffe00
I 16292000
W 0c 00000464
I 26b16000
W 0d 00000664
I 488d0000
W 11 00071c50
I 19442000
W 12 00071c55
I 49898000
W 13 fffff2d4
I 4a4e6000
W 14 00ad7f90
I 3b800001
W 17 00000001
I 3b800002
W 17 00000002
I 3bdc0010
W 17 00000012
I 00000000
I 00000000
I 1c5ee000
W 18 00000024

// File: vlog.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
rf/rf_dpram.sv
rf/rf_bypass.sv
hdl/mul_timer.sv
hdl/pipe_ctrl.sv
hdl/exec_unit.sv
hdl/core_top.sv
dv/tb_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_core -f vlog.f -o Vtb_core
	@out="$$(./obj_dir/Vtb_core)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
